// ==== Bender.yml ====
package:
  name: eth_mac_gmii

sources:
  - eth_gmii_pkg.sv
  - eth_crc32.sv
  - gmii_speed_detect.sv
  - gmii_tx_framer.sv
  - gmii_rx_checker.sv
  - eth_mac_ctrl.sv
  - eth_mac_gmii.sv
  - target: simulation
    files:
      - tb_eth_mac_gmii.sv

// ==== build.f ====
eth_gmii_pkg.sv
eth_crc32.sv
gmii_speed_detect.sv
gmii_tx_framer.sv
gmii_rx_checker.sv
eth_mac_ctrl.sv
eth_mac_gmii.sv
tb_eth_mac_gmii.sv

// ==== eth_crc32.sv ====
// Byte-wide reflected CRC-32 register for the Ethernet FCS
`timescale 1ns/10ps

module eth_crc32 (
    input  logic        gtx_clk,
    input  logic        gtx_rst,
    input  logic        clear,
    input  logic        update,
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    // Advances the CRC state by one byte, least significant bit first
    function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
        logic [31:0] c;
        c = c_in ^ {24'h000000, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ eth_gmii_pkg::CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1;
        end else if (update) begin
            crc <= crc_byte(crc, data);
        end
    end

endmodule

// ==== eth_gmii_pkg.sv ====
// Shared framing, CRC, speed detection and FSM constants for the gigabit GMII MAC
package eth_gmii_pkg;

    // Ethernet framing
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         PREAMBLE_LEN  = 7;
    localparam int         MIN_PAYLOAD   = 60;

    // Reflected CRC-32 and the state left behind by a frame with a correct FCS
    localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

    // Transmit buffer and host length field
    localparam int TX_BUF_DEPTH = 64;
    localparam int TX_ADDR_W    = $clog2(TX_BUF_DEPTH);
    localparam int LEN_W        = 7;

    // Interframe gap in gtx_clk cycles
    localparam int IFG_CYCLES = 12;
    localparam int IFG_CNT_W  = $clog2(IFG_CYCLES);

    // Speed detection; a window of 32 or more reference cycles means 100M
    localparam int          REF_COUNT_W  = 7;
    localparam int          REF_100M_MIN = 32;
    localparam logic [1:0]  SPEED_10M    = 2'd0;
    localparam logic [1:0]  SPEED_100M   = 2'd1;
    localparam logic [1:0]  SPEED_1000M  = 2'd2;

    // Control FSM states
    localparam logic [2:0] CTRL_IDLE    = 3'd0;
    localparam logic [2:0] CTRL_SEND    = 3'd1;
    localparam logic [2:0] CTRL_GAP     = 3'd2;
    localparam logic [2:0] CTRL_ACK     = 3'd3;
    localparam logic [2:0] CTRL_RELEASE = 3'd4;

    // Transmit sequencer states
    localparam logic [2:0] TX_IDLE     = 3'd0;
    localparam logic [2:0] TX_PREAMBLE = 3'd1;
    localparam logic [2:0] TX_SFD      = 3'd2;
    localparam logic [2:0] TX_PAYLOAD  = 3'd3;
    localparam logic [2:0] TX_PAD      = 3'd4;
    localparam logic [2:0] TX_FCS      = 3'd5;

    // Receive parser states
    localparam logic [1:0] RX_IDLE     = 2'd0;
    localparam logic [1:0] RX_PREAMBLE = 2'd1;
    localparam logic [1:0] RX_DATA     = 2'd2;
    localparam logic [1:0] RX_DROP     = 2'd3;

endpackage

// ==== eth_mac_ctrl.sv ====
// MAC control FSM for the transmit request handshake, interframe gap and enables
`timescale 1ns/10ps

module eth_mac_ctrl (
    input  logic                           gtx_clk,
    input  logic                           gtx_rst,
    input  logic                           tx_req,
    input  logic [eth_gmii_pkg::LEN_W-1:0] tx_len,
    output logic                           tx_ack,
    input  logic                           cfg_tx_enable,
    input  logic                           cfg_rx_enable,
    input  logic [1:0]                     link_speed,
    output logic                           tx_start,
    input  logic                           tx_done,
    output logic                           rx_enable
);

    logic [2:0]                         state;
    logic [eth_gmii_pkg::IFG_CNT_W-1:0] gap_cnt;
    logic                               len_ok;
    logic                               tx_allowed;

    assign len_ok = (tx_len != '0) &&
                    (tx_len <= eth_gmii_pkg::LEN_W'(eth_gmii_pkg::TX_BUF_DEPTH));
    assign tx_allowed = cfg_tx_enable && (link_speed == eth_gmii_pkg::SPEED_1000M);
    assign rx_enable  = cfg_rx_enable && (link_speed == eth_gmii_pkg::SPEED_1000M);

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state    <= eth_gmii_pkg::CTRL_IDLE;
            gap_cnt  <= '0;
            tx_ack   <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                eth_gmii_pkg::CTRL_IDLE: begin
                    if (tx_req) begin
                        if (!len_ok) begin
                            // Bad length is acknowledged without touching the wire
                            tx_ack <= 1'b1;
                            state  <= eth_gmii_pkg::CTRL_ACK;
                        end else if (tx_allowed) begin
                            tx_start <= 1'b1;
                            state    <= eth_gmii_pkg::CTRL_SEND;
                        end
                    end
                end
                eth_gmii_pkg::CTRL_SEND: begin
                    if (tx_done) begin
                        gap_cnt <= eth_gmii_pkg::IFG_CNT_W'(1);
                        state   <= eth_gmii_pkg::CTRL_GAP;
                    end
                end
                eth_gmii_pkg::CTRL_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == eth_gmii_pkg::IFG_CNT_W'(eth_gmii_pkg::IFG_CYCLES - 1)) begin
                        tx_ack <= 1'b1;
                        state  <= eth_gmii_pkg::CTRL_ACK;
                    end
                end
                eth_gmii_pkg::CTRL_ACK: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= eth_gmii_pkg::CTRL_RELEASE;
                    end
                end
                default: begin
                    state <= eth_gmii_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    a_ack_needs_req: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        $rose(tx_ack) |-> tx_req
    );

endmodule

// ==== eth_mac_gmii.sv ====
// Gigabit Ethernet MAC top level on an 8-bit GMII port
`timescale 1ns/10ps

module eth_mac_gmii (
    input  logic                           gtx_clk,
    input  logic                           gtx_rst,
    input  logic                           gmii_rx_clk,
    input  logic [7:0]                     gmii_rxd,
    input  logic                           gmii_rx_dv,
    input  logic                           gmii_rx_er,
    output logic [7:0]                     gmii_txd,
    output logic                           gmii_tx_en,
    output logic                           gmii_tx_er,
    input  logic                           tx_wr,
    input  logic [7:0]                     tx_wdata,
    input  logic                           tx_req,
    input  logic [eth_gmii_pkg::LEN_W-1:0] tx_len,
    output logic                           tx_ack,
    output logic [7:0]                     rx_data,
    output logic                           rx_valid,
    output logic                           rx_last,
    output logic                           rx_done,
    output logic                           rx_bad_fcs,
    output logic [1:0]                     link_speed,
    input  logic                           cfg_tx_enable,
    input  logic                           cfg_rx_enable
);

    logic tx_start;
    logic tx_done;
    logic rx_enable;

    gmii_speed_detect gmii_speed_detect_i (
        .gtx_clk     (gtx_clk),
        .gtx_rst     (gtx_rst),
        .gmii_rx_clk (gmii_rx_clk),
        .link_speed  (link_speed)
    );

    eth_mac_ctrl eth_mac_ctrl_i (
        .gtx_clk       (gtx_clk),
        .gtx_rst       (gtx_rst),
        .tx_req        (tx_req),
        .tx_len        (tx_len),
        .tx_ack        (tx_ack),
        .cfg_tx_enable (cfg_tx_enable),
        .cfg_rx_enable (cfg_rx_enable),
        .link_speed    (link_speed),
        .tx_start      (tx_start),
        .tx_done       (tx_done),
        .rx_enable     (rx_enable)
    );

    gmii_tx_framer gmii_tx_framer_i (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .tx_wr      (tx_wr),
        .tx_wdata   (tx_wdata),
        .tx_start   (tx_start),
        .tx_len     (tx_len),
        .tx_done    (tx_done),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    gmii_rx_checker gmii_rx_checker_i (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .rx_enable  (rx_enable),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_done    (rx_done),
        .rx_bad_fcs (rx_bad_fcs)
    );

endmodule

// ==== gmii_rx_checker.sv ====
// GMII receive parser that strips preamble and FCS and checks the frame CRC
`timescale 1ns/10ps

module gmii_rx_checker (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic       rx_enable,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_last,
    output logic       rx_done,
    output logic       rx_bad_fcs
);

    logic [1:0]       state;
    logic [2:0]       fill;
    logic             er_seen;
    logic [3:0][7:0]  dly;
    logic [31:0]      crc;
    logic             sfd_seen;
    logic             data_byte;

    assign sfd_seen  = (state == eth_gmii_pkg::RX_PREAMBLE) && gmii_rx_dv &&
                       (gmii_rxd == eth_gmii_pkg::SFD_BYTE);
    assign data_byte = (state == eth_gmii_pkg::RX_DATA) && gmii_rx_dv;

    // The byte on rx_data is the last payload byte once the frame has ended
    assign rx_last = rx_valid && !gmii_rx_dv;

    // Four-byte delay line holds back the FCS from the host
    always_ff @(posedge gtx_clk) begin
        if (data_byte) begin
            dly     <= {dly[2:0], gmii_rxd};
            rx_data <= dly[3];
        end
    end

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state      <= eth_gmii_pkg::RX_IDLE;
            fill       <= '0;
            er_seen    <= 1'b0;
            rx_valid   <= 1'b0;
            rx_done    <= 1'b0;
            rx_bad_fcs <= 1'b0;
        end else begin
            rx_valid   <= 1'b0;
            rx_done    <= 1'b0;
            rx_bad_fcs <= 1'b0;
            case (state)
                eth_gmii_pkg::RX_IDLE: begin
                    if (gmii_rx_dv) begin
                        if (rx_enable && gmii_rxd == eth_gmii_pkg::PREAMBLE_BYTE) begin
                            state <= eth_gmii_pkg::RX_PREAMBLE;
                        end else begin
                            state <= eth_gmii_pkg::RX_DROP;
                        end
                    end
                end
                eth_gmii_pkg::RX_PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= eth_gmii_pkg::RX_IDLE;
                    end else if (sfd_seen) begin
                        state   <= eth_gmii_pkg::RX_DATA;
                        fill    <= '0;
                        er_seen <= gmii_rx_er;
                    end else if (gmii_rxd != eth_gmii_pkg::PREAMBLE_BYTE) begin
                        state <= eth_gmii_pkg::RX_DROP;
                    end
                end
                eth_gmii_pkg::RX_DATA: begin
                    if (gmii_rx_dv) begin
                        er_seen <= er_seen | gmii_rx_er;
                        if (fill == 3'd4) begin
                            rx_valid <= 1'b1;
                        end else begin
                            fill <= fill + 3'd1;
                        end
                    end else begin
                        state      <= eth_gmii_pkg::RX_IDLE;
                        rx_done    <= 1'b1;
                        rx_bad_fcs <= er_seen || (crc != eth_gmii_pkg::CRC_RESIDUE);
                    end
                end
                default: begin
                    // Discarded frame, wait for the carrier to drop
                    if (!gmii_rx_dv) begin
                        state <= eth_gmii_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    eth_crc32 eth_crc32_i (
        .gtx_clk (gtx_clk),
        .gtx_rst (gtx_rst),
        .clear   (sfd_seen),
        .update  (data_byte),
        .data    (gmii_rxd),
        .crc     (crc)
    );

endmodule

// ==== gmii_speed_detect.sv ====
// Link speed detector that times the prescaled GMII receive clock against gtx_clk
`timescale 1ns/10ps

module gmii_speed_detect (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic       gmii_rx_clk,
    output logic [1:0] link_speed
);

    logic [2:0]                           rx_prescale = 3'd0;
    logic [2:0]                           rx_prescale_sync;
    logic [eth_gmii_pkg::REF_COUNT_W-1:0] ref_count;
    logic [1:0]                           edge_count;

    // Free-running divide by eight of the receive clock
    always_ff @(posedge gmii_rx_clk) begin
        rx_prescale <= rx_prescale + 3'd1;
    end

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            rx_prescale_sync <= '0;
            ref_count        <= '0;
            edge_count       <= '0;
            link_speed       <= eth_gmii_pkg::SPEED_1000M;
        end else begin
            rx_prescale_sync <= {rx_prescale_sync[1:0], rx_prescale[2]};
            if (edge_count == 2'd3) begin
                // Three prescaled toggles seen before the window ran out
                ref_count  <= '0;
                edge_count <= '0;
                if (ref_count >= eth_gmii_pkg::REF_COUNT_W'(eth_gmii_pkg::REF_100M_MIN)) begin
                    link_speed <= eth_gmii_pkg::SPEED_100M;
                end else begin
                    link_speed <= eth_gmii_pkg::SPEED_1000M;
                end
            end else if (&ref_count) begin
                // Window expired, so the receive clock is the slow 2.5 MHz one
                ref_count  <= '0;
                edge_count <= '0;
                link_speed <= eth_gmii_pkg::SPEED_10M;
            end else begin
                ref_count <= ref_count + 1'b1;
                if (rx_prescale_sync[2] ^ rx_prescale_sync[1]) begin
                    edge_count <= edge_count + 2'd1;
                end
            end
        end
    end

    a_speed_code_legal: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        link_speed != 2'd3
    );

endmodule

// ==== gmii_tx_framer.sv ====
// GMII transmit framer with payload buffer, preamble, zero padding and FCS insertion
`timescale 1ns/10ps

module gmii_tx_framer (
    input  logic                           gtx_clk,
    input  logic                           gtx_rst,
    input  logic                           tx_wr,
    input  logic [7:0]                     tx_wdata,
    input  logic                           tx_start,
    input  logic [eth_gmii_pkg::LEN_W-1:0] tx_len,
    output logic                           tx_done,
    output logic [7:0]                     gmii_txd,
    output logic                           gmii_tx_en,
    output logic                           gmii_tx_er
);

    logic [7:0]                           buf_mem [eth_gmii_pkg::TX_BUF_DEPTH];
    logic [eth_gmii_pkg::TX_ADDR_W-1:0]   wr_ptr;
    logic [2:0]                           state;
    logic [eth_gmii_pkg::LEN_W-1:0]       cnt;
    logic [eth_gmii_pkg::LEN_W-1:0]       len_reg;
    logic [7:0]                           next_byte;
    logic [31:0]                          crc;
    logic [31:0]                          fcs;
    logic                                 crc_update;

    assign fcs        = ~crc;
    assign crc_update = (state == eth_gmii_pkg::TX_PAYLOAD) || (state == eth_gmii_pkg::TX_PAD);
    assign gmii_tx_er = 1'b0;

    // Byte that goes onto the wire at the next clock edge
    always_comb begin
        case (state)
            eth_gmii_pkg::TX_IDLE:     next_byte = tx_start ? eth_gmii_pkg::PREAMBLE_BYTE : 8'h00;
            eth_gmii_pkg::TX_PREAMBLE: next_byte = eth_gmii_pkg::PREAMBLE_BYTE;
            eth_gmii_pkg::TX_SFD:      next_byte = eth_gmii_pkg::SFD_BYTE;
            eth_gmii_pkg::TX_PAYLOAD:  next_byte = buf_mem[cnt[eth_gmii_pkg::TX_ADDR_W-1:0]];
            eth_gmii_pkg::TX_FCS:      next_byte = fcs[8*cnt[1:0] +: 8];
            default:                   next_byte = 8'h00;
        endcase
    end

    always_ff @(posedge gtx_clk) begin
        if (tx_wr) begin
            buf_mem[wr_ptr] <= tx_wdata;
        end
        if (tx_start) begin
            len_reg <= tx_len;
        end
        gmii_txd <= next_byte;
    end

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state      <= eth_gmii_pkg::TX_IDLE;
            cnt        <= '0;
            wr_ptr     <= '0;
            gmii_tx_en <= 1'b0;
            tx_done    <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            // The host refills the buffer from address zero after each send
            if (tx_done) begin
                wr_ptr <= '0;
            end else if (tx_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                eth_gmii_pkg::TX_IDLE: begin
                    gmii_tx_en <= tx_start;
                    if (tx_start) begin
                        state <= eth_gmii_pkg::TX_PREAMBLE;
                        cnt   <= eth_gmii_pkg::LEN_W'(1);
                    end
                end
                eth_gmii_pkg::TX_PREAMBLE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == eth_gmii_pkg::LEN_W'(eth_gmii_pkg::PREAMBLE_LEN - 1)) begin
                        state <= eth_gmii_pkg::TX_SFD;
                    end
                end
                eth_gmii_pkg::TX_SFD: begin
                    state <= eth_gmii_pkg::TX_PAYLOAD;
                    cnt   <= '0;
                end
                eth_gmii_pkg::TX_PAYLOAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == len_reg - 1'b1) begin
                        if (len_reg < eth_gmii_pkg::LEN_W'(eth_gmii_pkg::MIN_PAYLOAD)) begin
                            state <= eth_gmii_pkg::TX_PAD;
                        end else begin
                            state <= eth_gmii_pkg::TX_FCS;
                            cnt   <= '0;
                        end
                    end
                end
                eth_gmii_pkg::TX_PAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == eth_gmii_pkg::LEN_W'(eth_gmii_pkg::MIN_PAYLOAD - 1)) begin
                        state <= eth_gmii_pkg::TX_FCS;
                        cnt   <= '0;
                    end
                end
                default: begin
                    // FCS bytes go out least significant byte first
                    cnt <= cnt + 1'b1;
                    if (cnt[1:0] == 2'd3) begin
                        state   <= eth_gmii_pkg::TX_IDLE;
                        tx_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    eth_crc32 eth_crc32_i (
        .gtx_clk (gtx_clk),
        .gtx_rst (gtx_rst),
        .clear   (tx_start),
        .update  (crc_update),
        .data    (next_byte),
        .crc     (crc)
    );

    a_start_when_idle: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        tx_start |-> state == eth_gmii_pkg::TX_IDLE
    );

endmodule

// ==== tb_eth_mac_gmii.sv ====
// Testbench for the GMII Ethernet MAC with loopback, link speed sweep and a frame table
`timescale 1ns/10ps

module tb_eth_mac_gmii;

    localparam int CLK_HALF   = 10;
    localparam int WAIT_LIMIT = 3000;
    localparam int NUM_FRAMES = 7;
    // Seven preamble bytes and the SFD come first, so wire byte 10 is payload byte 2
    localparam int CORRUPT_IDX = 10;
    localparam int PAYLOAD_OFS = eth_gmii_pkg::PREAMBLE_LEN + 1;

    // Frame table with payload length, corrupt, receive enable and expected drop flags
    int frame_len     [NUM_FRAMES] = '{64, 10, 20, 0, 30, 60, 70};
    bit frame_corrupt [NUM_FRAMES] = '{0, 0, 1, 0, 0, 0, 0};
    bit frame_rx_en   [NUM_FRAMES] = '{1, 1, 1, 1, 0, 1, 1};
    bit frame_drop    [NUM_FRAMES] = '{0, 0, 0, 1, 0, 0, 1};

    // Receive clock half periods in ns, ending back at the gigabit rate
    int speed_half [4] = '{4, 40, 200, 4};

    logic                           gtx_clk = 1'b0;
    logic                           gtx_rst;
    logic                           gmii_rx_clk = 1'b0;
    logic [7:0]                     gmii_rxd;
    logic                           gmii_rx_dv;
    logic                           gmii_rx_er;
    logic [7:0]                     gmii_txd;
    logic                           gmii_tx_en;
    logic                           gmii_tx_er;
    logic                           tx_wr;
    logic [7:0]                     tx_wdata;
    logic                           tx_req;
    logic [eth_gmii_pkg::LEN_W-1:0] tx_len;
    logic                           tx_ack;
    logic [7:0]                     rx_data;
    logic                           rx_valid;
    logic                           rx_last;
    logic                           rx_done;
    logic                           rx_bad_fcs;
    logic [1:0]                     link_speed;
    logic                           cfg_tx_enable;
    logic                           cfg_rx_enable;

    int         rx_half = 4;
    logic       corrupt_en = 1'b0;
    int         tx_idx = 0;
    logic [7:0] rx_bytes [$];
    int         rx_done_cnt = 0;
    logic       rx_bad_seen = 1'b0;
    int         rx_last_pos = 0;
    int         rx_last_cnt = 0;
    int         tx_en_cnt = 0;

    always #(CLK_HALF) gtx_clk = ~gtx_clk;
    always #(rx_half) gmii_rx_clk = ~gmii_rx_clk;

    // Loopback from the transmit pins to the receive pins, with one bit flipped on request
    assign gmii_rxd   = gmii_txd ^ ((corrupt_en && gmii_tx_en && tx_idx == CORRUPT_IDX) ?
                                    8'h01 : 8'h00);
    assign gmii_rx_dv = gmii_tx_en;
    assign gmii_rx_er = gmii_tx_er;

    eth_mac_gmii eth_mac_gmii_i (
        .gtx_clk       (gtx_clk),
        .gtx_rst       (gtx_rst),
        .gmii_rx_clk   (gmii_rx_clk),
        .gmii_rxd      (gmii_rxd),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rx_er    (gmii_rx_er),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_tx_er    (gmii_tx_er),
        .tx_wr         (tx_wr),
        .tx_wdata      (tx_wdata),
        .tx_req        (tx_req),
        .tx_len        (tx_len),
        .tx_ack        (tx_ack),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_last       (rx_last),
        .rx_done       (rx_done),
        .rx_bad_fcs    (rx_bad_fcs),
        .link_speed    (link_speed),
        .cfg_tx_enable (cfg_tx_enable),
        .cfg_rx_enable (cfg_rx_enable)
    );

    // Position of the current byte within the transmitted frame
    always @(posedge gtx_clk) begin
        tx_idx <= gmii_tx_en ? tx_idx + 1 : 0;
    end

    // Collects everything the MAC delivers on the host receive side
    always @(posedge gtx_clk) begin
        check("gmii_tx_er", gmii_tx_er, 1'b0);
        if (gmii_tx_en) begin
            tx_en_cnt = tx_en_cnt + 1;
        end
        if (rx_valid) begin
            rx_bytes.push_back(rx_data);
            if (rx_last) begin
                rx_last_pos = rx_bytes.size();
            end
        end
        if (rx_last) begin
            rx_last_cnt = rx_last_cnt + 1;
        end
        if (rx_done) begin
            rx_done_cnt = rx_done_cnt + 1;
            rx_bad_seen = rx_bad_fcs;
        end
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // The prescaled bit toggles every eight receive half periods and three toggles end a window
    function automatic logic [1:0] expected_speed(input int half_ns);
        real window;
        window = 3.0 * 8.0 * half_ns / (2.0 * CLK_HALF);
        if (window >= real'((1 << eth_gmii_pkg::REF_COUNT_W) - 1)) begin
            return eth_gmii_pkg::SPEED_10M;
        end else if (window >= real'(eth_gmii_pkg::REF_100M_MIN)) begin
            return eth_gmii_pkg::SPEED_100M;
        end
        return eth_gmii_pkg::SPEED_1000M;
    endfunction

    task automatic wait_speed(input logic [1:0] exp);
        int n;
        n = 0;
        while (link_speed !== exp) begin
            if (n >= WAIT_LIMIT) begin
                $display("Timeout: link_speed never reached %0d", exp);
                abort_run();
            end
            @(posedge gtx_clk);
            n++;
        end
        // Several more windows must agree before the value counts as settled
        repeat (400) @(posedge gtx_clk);
        check("link_speed", link_speed, exp);
    endtask

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (tx_ack !== level) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout: tx_ack did not go to %0b", level);
                abort_run();
            end
            @(posedge gtx_clk);
            cycles++;
        end
    endtask

    task automatic run_frame(input int len, input bit corrupt, input bit rx_en, input bit drop,
                             input bit hold);
        logic [7:0] exp_bytes [$];
        int         exp_len;
        int         cycles;
        exp_len     = (len > eth_gmii_pkg::MIN_PAYLOAD) ? len : eth_gmii_pkg::MIN_PAYLOAD;
        rx_bytes.delete();
        rx_done_cnt = 0;
        rx_bad_seen = 1'b0;
        rx_last_pos = 0;
        rx_last_cnt = 0;
        tx_en_cnt   = 0;
        @(posedge gtx_clk);
        cfg_rx_enable <= rx_en;
        cfg_tx_enable <= !hold;
        corrupt_en    <= corrupt;
        // A dropped request never resets the write pointer, so nothing is written for it
        if (!drop) begin
            for (int i = 0; i < len; i++) begin
                exp_bytes.push_back(8'($urandom));
                @(posedge gtx_clk);
                tx_wr    <= 1'b1;
                tx_wdata <= exp_bytes[i];
            end
        end
        while (exp_bytes.size() < exp_len) begin
            exp_bytes.push_back(8'h00);
        end
        if (corrupt) begin
            exp_bytes[CORRUPT_IDX - PAYLOAD_OFS] = exp_bytes[CORRUPT_IDX - PAYLOAD_OFS] ^ 8'h01;
        end
        @(posedge gtx_clk);
        tx_wr <= 1'b0;
        check("tx_ack", tx_ack, 1'b0);
        tx_len <= eth_gmii_pkg::LEN_W'(len);
        tx_req <= 1'b1;
        if (hold) begin
            repeat (100) begin
                @(posedge gtx_clk);
                check("tx_ack", tx_ack, 1'b0);
            end
            check("gmii_tx_en cycles", tx_en_cnt, 0);
            cfg_tx_enable <= 1'b1;
        end
        wait_ack(1'b1, cycles);
        // The host stalls and tx_ack has to stay up until the request drops
        repeat (3) begin
            @(posedge gtx_clk);
            check("tx_ack", tx_ack, 1'b1);
        end
        tx_req <= 1'b0;
        wait_ack(1'b0, cycles);
        check("tx_ack release cycles", cycles, 2);

        if (drop) begin
            check("gmii_tx_en cycles", tx_en_cnt, 0);
        end else begin
            check("gmii_tx_en cycles", tx_en_cnt, PAYLOAD_OFS + exp_len + 4);
        end
        if (drop || !rx_en) begin
            check("rx_valid count", rx_bytes.size(), 0);
            check("rx_last count", rx_last_cnt, 0);
            check("rx_done count", rx_done_cnt, 0);
        end else begin
            check("rx_done count", rx_done_cnt, 1);
            check("rx_bad_fcs", rx_bad_seen, corrupt);
            check("rx_valid count", rx_bytes.size(), exp_len);
            check("rx_last count", rx_last_cnt, 1);
            check("rx_last position", rx_last_pos, exp_len);
            for (int i = 0; i < exp_len; i++) begin
                check("rx_data", rx_bytes[i], exp_bytes[i]);
            end
        end
    endtask

    initial begin
        gtx_rst       = 1'b1;
        tx_wr         = 1'b0;
        tx_wdata      = 8'h00;
        tx_req        = 1'b0;
        tx_len        = '0;
        cfg_tx_enable = 1'b0;
        cfg_rx_enable = 1'b0;
        void'($urandom(32'hf2e6_f837));
        repeat (5) @(posedge gtx_clk);
        gtx_rst <= 1'b0;
        check("link_speed", link_speed, eth_gmii_pkg::SPEED_1000M);
        check("tx_ack", tx_ack, 1'b0);
        check("gmii_tx_en", gmii_tx_en, 1'b0);
        check("rx_valid", rx_valid, 1'b0);
        check("rx_done", rx_done, 1'b0);
        check("rx_bad_fcs", rx_bad_fcs, 1'b0);

        foreach (speed_half[i]) begin
            rx_half = speed_half[i];
            wait_speed(expected_speed(speed_half[i]));
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(frame_len[f], frame_corrupt[f], frame_rx_en[f], frame_drop[f], 1'b0);
        end
        // Request held back by a disabled transmitter, then released
        run_frame(61, 1'b0, 1'b1, 1'b0, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
